// File: src/tinker_params.svh
`ifndef TINKER_PARAMS_SVH
`define TINKER_PARAMS_SVH

// data path and pc width
`define XLEN 64

// instruction word width
`define ILEN 32

// opcode and register index fields
`define OP_W 5
`define REG_IDX_W 5

// raw L field, sign-extended in decode
`define IMM_W 12

// data memory address width
`define DADDR_W 32

// 256-word instruction memory
`define IMEM_AW 8

// first fetch address
`define RESET_PC 'h2000

`endif

// File: src/tinker_pkg.sv
`include "tinker_params.svh"

package tinker_pkg;

    // register values, alu results, pc values
    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`ILEN-1:0] instr_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    // L field before extension
    typedef logic [`IMM_W-1:0] imm_t;
    typedef logic [`DADDR_W-1:0] daddr_t;
    // loader word index
    typedef logic [`IMEM_AW-1:0] imem_addr_t;

    // instruction bits 31..27
    // all-zero word decodes as and r0,r0,r0
    typedef enum logic [`OP_W-1:0] {
        op_and    = 5'b00000,
        op_or     = 5'b00001,
        op_xor    = 5'b00010,
        op_not    = 5'b00011,
        op_shftr  = 5'b00100,
        op_shftri = 5'b00101,
        op_shftl  = 5'b00110,
        op_shftli = 5'b00111,
        op_jump   = 5'b01000,
        op_brnz   = 5'b01011,
        op_halt   = 5'b01111,
        op_load   = 5'b10000,
        op_mov    = 5'b10001,
        op_mov_l  = 5'b10010,
        op_store  = 5'b10011,
        op_add    = 5'b11000,
        op_addi   = 5'b11001,
        op_sub    = 5'b11010,
        op_subi   = 5'b11011
    } opcode_t;

endpackage

// File: src/instr_mem.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module instr_mem import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  instr_t     load_data,
    input  word_t      pc,
    output instr_t     instr
);

    // one instruction per word
    instr_t mem [0:(1 << `IMEM_AW)-1];

    // loader port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // fetch read, word index from pc bits IMEM_AW+1..2
    assign instr = mem[pc[`IMEM_AW+1:2]];

    // program image only changes while the core is held in reset
    load_only_in_reset: assert property (@(posedge clk) load_en |-> reset)
        else $error("instr_mem: load_en high outside reset");

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t rd_idx,
    input  reg_idx_t wb_rd,
    input  logic     wb_en,
    input  word_t    wb_data,
    output word_t    rs_val,
    output word_t    rt_val,
    output word_t    rd_val
);

    localparam int num_regs = 1 << $bits(reg_idx_t);

    word_t regs [0:num_regs-1];

    // r0 reads zero
    // same-cycle writeback passes straight through to decode
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_en && wb_rd == idx) begin
            val = wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
        rd_val = read_port(rd_idx);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module fetch_stage import tinker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t instr,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output word_t  pc,
    output word_t  if_pc,
    output instr_t if_instr
);

    // pc and if/id register
    // priority: redirect, then stall, then sequential fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= `RESET_PC;
            if_pc    <= '0;
            if_instr <= '0;
        end else if (redirect) begin
            // taken branch sits in ex/mem
            // sequential fetch is wrong path
            pc       <= redirect_pc;
            if_pc    <= '0;
            if_instr <= '0;
        end else if (!stall) begin
            pc       <= pc + word_t'(4);
            if_pc    <= pc;
            if_instr <= instr;
        end
        // load-use stall holds pc and if/id
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch_stage: pc not word aligned");

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    if_pc,
    input  instr_t   if_instr,
    input  logic     redirect,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    rd_val,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output reg_idx_t rd_idx,
    output opcode_t  id_op,
    output reg_idx_t id_rd,
    output reg_idx_t id_rs,
    output reg_idx_t id_rt,
    output logic     id_use_rs,
    output logic     id_use_rt,
    output logic     id_use_rd,
    output word_t    id_a,
    output word_t    id_b,
    output word_t    id_c,
    output word_t    id_imm,
    output word_t    id_pc,
    output logic     stall
);

    opcode_t op;
    imm_t    lit;
    logic    use_rs;
    logic    use_rt;
    logic    use_rd;

    // field split
    assign op     = opcode_t'(if_instr[31:27]);
    assign rd_idx = if_instr[26:22];
    assign rs_idx = if_instr[21:17];
    assign rt_idx = if_instr[16:12];
    assign lit    = if_instr[11:0];

    // which registers the opcode reads
    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        use_rd = 1'b0;
        case (op)
            op_and, op_or, op_xor, op_shftr, op_shftl, op_add, op_sub: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            op_not, op_mov, op_load: use_rs = 1'b1;
            // immediate forms work on rd, mov_L keeps rd upper bits
            op_addi, op_subi, op_shftri, op_shftli, op_mov_l, op_jump: use_rd = 1'b1;
            // store: rd is the base, rs the data
            // brnz: rd is the target, rs the condition
            op_store, op_brnz: begin
                use_rs = 1'b1;
                use_rd = 1'b1;
            end
            default: ;
        endcase
    end

    // load in id/ex feeding a source here, its data only exists after mem
    assign stall = (id_op == op_load) && (id_rd != '0) &&
                   ((use_rs && rs_idx == id_rd) ||
                    (use_rt && rt_idx == id_rd) ||
                    (use_rd && rd_idx == id_rd));

    // id/ex control, bubble on flush or stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_op     <= op_and;
            id_rd     <= '0;
            id_rs     <= '0;
            id_rt     <= '0;
            id_use_rs <= 1'b0;
            id_use_rt <= 1'b0;
            id_use_rd <= 1'b0;
        end else if (redirect || stall) begin
            id_op     <= op_and;
            id_rd     <= '0;
            id_rs     <= '0;
            id_rt     <= '0;
            id_use_rs <= 1'b0;
            id_use_rt <= 1'b0;
            id_use_rd <= 1'b0;
        end else begin
            id_op     <= op;
            id_rd     <= rd_idx;
            id_rs     <= rs_idx;
            id_rt     <= rt_idx;
            id_use_rs <= use_rs;
            id_use_rt <= use_rt;
            id_use_rd <= use_rd;
        end
    end

    // id/ex operands, meaningless under a bubble
    always_ff @(posedge clk) begin
        id_a   <= rs_val;
        id_b   <= rt_val;
        id_c   <= rd_val;
        id_imm <= word_t'($signed(lit));
        id_pc  <= if_pc;
    end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module execute_stage import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  opcode_t  id_op,
    input  reg_idx_t id_rd,
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_use_rs,
    input  logic     id_use_rt,
    input  logic     id_use_rd,
    input  word_t    id_a,
    input  word_t    id_b,
    input  word_t    id_c,
    input  word_t    id_imm,
    input  word_t    id_pc,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    output opcode_t  ex_op,
    output reg_idx_t ex_rd,
    output logic     ex_wen,
    output logic     ex_mem_write,
    output daddr_t   ex_addr,
    output word_t    ex_result,
    output word_t    ex_store_data,
    output logic     redirect,
    output word_t    redirect_pc
);

    word_t a;
    word_t b;
    word_t c;
    word_t result;
    word_t addr_full;
    logic  writes;
    logic  mem_write;
    logic  taken;
    logic  flush;
    logic  halted;

    // youngest producer wins
    // a load in ex/mem has no data yet, the stall covers it
    function automatic word_t forward(input logic used, input reg_idx_t idx, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (used && idx != '0) begin
            if (ex_wen && ex_rd == idx && ex_op != op_load) begin
                val = ex_result;
            end else if (wb_en && wb_rd == idx) begin
                val = wb_data;
            end
        end
        return val;
    endfunction

    always_comb begin
        a         = forward(id_use_rs, id_rs, id_a);
        b         = forward(id_use_rt, id_rt, id_b);
        c         = forward(id_use_rd, id_rd, id_c);
        result    = '0;
        addr_full = '0;
        writes    = 1'b1;
        mem_write = 1'b0;
        taken     = 1'b0;
        case (id_op)
            op_and:    result = a & b;
            op_or:     result = a | b;
            op_xor:    result = a ^ b;
            op_not:    result = ~a;
            // full 64-bit shift amount, 64 and up gives zero
            op_shftr:  result = a >> b;
            op_shftri: result = c >> id_imm;
            op_shftl:  result = a << b;
            op_shftli: result = c << id_imm;
            op_mov:    result = a;
            op_mov_l:  result = {c[`XLEN-1:12], id_imm[11:0]};
            op_add:    result = a + b;
            op_addi:   result = c + id_imm;
            op_sub:    result = a - b;
            op_subi:   result = c - id_imm;
            // result comes from dmem in the next stage
            op_load:   addr_full = a + id_imm;
            op_store: begin
                writes    = 1'b0;
                mem_write = 1'b1;
                addr_full = c + id_imm;
            end
            op_jump: begin
                writes = 1'b0;
                taken  = 1'b1;
            end
            op_brnz: begin
                writes = 1'b0;
                taken  = (a != '0);
            end
            // halt and unused codes
            default: writes = 1'b0;
        endcase
    end

    // target equal to the fall-through address needs no flush
    assign flush = taken && (c != id_pc + word_t'(4));

    // ex/mem control
    // bubble while the redirect is applied and for good once halt has passed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_op        <= op_and;
            ex_rd        <= '0;
            ex_wen       <= 1'b0;
            ex_mem_write <= 1'b0;
            redirect     <= 1'b0;
            halted       <= 1'b0;
        end else if (redirect || halted) begin
            ex_op        <= op_and;
            ex_rd        <= '0;
            ex_wen       <= 1'b0;
            ex_mem_write <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            ex_op        <= id_op;
            ex_rd        <= id_rd;
            ex_wen       <= writes && (id_rd != '0);
            ex_mem_write <= mem_write;
            redirect     <= flush;
            halted       <= (id_op == op_halt);
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        ex_addr       <= addr_full[`DADDR_W-1:0];
        ex_result     <= result;
        ex_store_data <= a;
        redirect_pc   <= c;
    end

    // id/ex opcode comes from decode, must be resolved every cycle
    op_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(id_op))
        else $error("execute_stage: unknown opcode in id/ex");

endmodule

// File: src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  opcode_t  ex_op,
    input  reg_idx_t ex_rd,
    input  logic     ex_wen,
    input  logic     ex_mem_write,
    input  daddr_t   ex_addr,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    input  word_t    dmem_rdata,
    output daddr_t   dmem_addr,
    output logic     dmem_write,
    output word_t    dmem_wdata,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     hlt
);

    logic wb_halt;

    // data port straight from ex/mem
    // store write lasts exactly the one ex/mem cycle
    assign dmem_addr  = ex_addr;
    assign dmem_write = ex_mem_write;
    assign dmem_wdata = ex_store_data;

    // mem/wb control and sticky halt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_halt <= 1'b0;
            hlt     <= 1'b0;
        end else begin
            wb_en   <= ex_wen;
            wb_rd   <= ex_rd;
            wb_halt <= (ex_op == op_halt);
            // rises the cycle after halt lands in mem/wb
            if (wb_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    // writeback select, load data or alu result
    always_ff @(posedge clk) begin
        wb_data <= (ex_op == op_load) ? dmem_rdata : ex_result;
    end

    // execute squashes everything behind a halt
    no_store_after_halt: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !dmem_write)
        else $error("memory_stage: store issued after halt");

endmodule

// File: src/tinker_core.sv
`timescale 1ns/1ps

module tinker_core import tinker_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  instr_t     load_data,
    output daddr_t     dmem_addr,
    output logic       dmem_write,
    output word_t      dmem_wdata,
    input  word_t      dmem_rdata,
    output logic       hlt
);

    // fetch
    word_t    pc;
    instr_t   instr;
    word_t    if_pc;
    instr_t   if_instr;
    logic     stall;

    // register file read ports
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;
    word_t    rs_val;
    word_t    rt_val;
    word_t    rd_val;

    // id/ex
    opcode_t  id_op;
    reg_idx_t id_rd;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    logic     id_use_rs;
    logic     id_use_rt;
    logic     id_use_rd;
    word_t    id_a;
    word_t    id_b;
    word_t    id_c;
    word_t    id_imm;
    word_t    id_pc;

    // ex/mem and branch redirect
    opcode_t  ex_op;
    reg_idx_t ex_rd;
    logic     ex_wen;
    logic     ex_mem_write;
    daddr_t   ex_addr;
    word_t    ex_result;
    word_t    ex_store_data;
    logic     redirect;
    word_t    redirect_pc;

    // writeback, also the older forwarding source
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // port names match the nets above
    instr_mem     instr_mem_inst     (.*);
    register_file register_file_inst (.*);
    fetch_stage   fetch_stage_inst   (.*);
    decode_stage  decode_stage_inst  (.*);
    execute_stage execute_stage_inst (.*);
    memory_stage  memory_stage_inst  (.*);

endmodule

// File: bench/tinker_core_tb.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_core_tb import tinker_pkg::*; ();

    localparam int clk_period  = 40;
    localparam int num_tests   = 5;
    // load of 256 words plus program run and slack
    localparam int test_cycles = 400;
    localparam int max_cycles  = num_tests * test_cycles;
    localparam int hlt_wait    = 100;
    localparam int imem_words  = 1 << `IMEM_AW;

    logic       clk;
    logic       reset;
    logic       load_en;
    imem_addr_t load_addr;
    instr_t     load_data;
    daddr_t     dmem_addr;
    logic       dmem_write;
    word_t      dmem_wdata;
    word_t      dmem_rdata;
    logic       hlt;

    // data memory model and store log
    word_t  dmem [daddr_t];
    int     dmem_updates;
    daddr_t store_addr [$];
    word_t  store_data [$];
    daddr_t exp_addr [$];
    word_t  exp_data [$];
    instr_t prog [$];

    int seed;
    int cycles;
    int errors;
    int pass_count;
    int fail_count;

    tinker_core tinker_core_inst (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .dmem_addr  (dmem_addr),
        .dmem_write (dmem_write),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

    // L field sign-extended to a full word
    function automatic word_t sext(input imm_t l);
        return {{(`XLEN - `IMM_W){l[`IMM_W-1]}}, l};
    endfunction

    function automatic imm_t rand_imm();
        int r;
        r = $random(seed);
        return r[`IMM_W-1:0];
    endfunction

    // unwritten words read as a pattern over the whole address
    function automatic word_t fill_word(input daddr_t a);
        return {~a, a};
    endfunction

    // combinational read that also refreshes after every write
    always @(dmem_addr or dmem_updates) begin
        if ($isunknown(dmem_addr)) begin
            dmem_rdata = '0;
        end else if (dmem.exists(dmem_addr)) begin
            dmem_rdata = dmem[dmem_addr];
        end else begin
            dmem_rdata = fill_word(dmem_addr);
        end
    end

    // stores logged in arrival order
    always @(posedge clk) begin
        if (dmem_write === 1'b1) begin
            dmem[dmem_addr] = dmem_wdata;
            store_addr.push_back(dmem_addr);
            store_data.push_back(dmem_wdata);
            dmem_updates++;
        end
    end

    task automatic add_instr(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                             input reg_idx_t rt, input imm_t l);
        prog.push_back({op, rd, rs, rt, l});
    endtask

    task automatic expect_store(input daddr_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic clear_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    // reset and program load, then release and wait for hlt
    task automatic run_program(output logic halted);
        int waited;
        @(posedge clk);
        #2;
        reset   = 1'b1;
        load_en = 1'b0;
        repeat (2) @(posedge clk);
        dmem.delete();
        store_addr.delete();
        store_data.delete();
        // unused words stay as the all-zero no-op
        for (int i = 0; i < imem_words; i++) begin
            #2;
            load_en   = 1'b1;
            load_addr = imem_addr_t'(i);
            load_data = (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
        end
        #2;
        load_en = 1'b0;
        reset   = 1'b0;
        waited  = 0;
        @(negedge clk);
        while (hlt !== 1'b1 && waited < hlt_wait) begin
            @(negedge clk);
            waited++;
        end
        halted = (hlt === 1'b1);
    endtask

    task automatic check_stores();
        int n;
        n = (store_addr.size() < exp_addr.size()) ? store_addr.size() : exp_addr.size();
        assert (store_addr.size() == exp_addr.size()) else begin
            $display("store count wrong: %0d stores seen, %0d expected",
                     store_addr.size(), exp_addr.size());
            errors++;
        end
        for (int i = n; i < exp_addr.size(); i++) begin
            $display("missing store to address %h", exp_addr[i]);
        end
        for (int i = n; i < store_addr.size(); i++) begin
            $display("extra store to address %h", store_addr[i]);
        end
        for (int i = 0; i < n; i++) begin
            assert (store_addr[i] == exp_addr[i]) else begin
                $display("error at %0d ns: store %0d went to %h, expected %h",
                         $time, i, store_addr[i], exp_addr[i]);
                errors++;
            end
            assert (store_data[i] == exp_data[i]) else begin
                $display("error at %0d ns: store %0d to %h wrote %h, expected %h",
                         $time, i, store_addr[i], store_data[i], exp_data[i]);
                errors++;
            end
        end
    endtask

    // hold counts the cycles that hlt must stay high after it rises
    task automatic run_and_check(input string name, input int hold);
        int   err0;
        logic halted;
        err0 = errors;
        run_program(halted);
        assert (halted) else begin
            $display("%s: hlt did not rise within %0d cycles", name, hlt_wait);
            errors++;
        end
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            assert (hlt === 1'b1) else begin
                $display("%s: hlt dropped %0d cycles after rising", name, i + 1);
                errors++;
            end
        end
        check_stores();
        if (errors == err0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors - err0);
        end
    endtask

    // dependent chain with no gaps between producers and consumers
    task automatic test_arith();
        imm_t  v1;
        imm_t  v2;
        imm_t  v3;
        imm_t  v4;
        word_t r1;
        word_t r3;
        word_t r4;
        clear_test();
        v1 = rand_imm();
        v2 = rand_imm();
        v3 = rand_imm();
        v4 = rand_imm();
        add_instr(op_mov_l, 1, 0, 0, v1);
        add_instr(op_mov_l, 2, 0, 0, v2);
        add_instr(op_addi, 1, 0, 0, v3);
        add_instr(op_add, 3, 1, 2, 0);
        add_instr(op_sub, 4, 2, 3, 0);
        add_instr(op_subi, 4, 0, 0, v4);
        add_instr(op_store, 0, 1, 0, 12'h100);
        add_instr(op_store, 0, 3, 0, 12'h108);
        add_instr(op_store, 0, 4, 0, 12'h110);
        add_instr(op_halt, 0, 0, 0, 0);
        // registers start at zero so mov_L gives the raw field
        r1 = word_t'(v1) + sext(v3);
        r3 = r1 + word_t'(v2);
        r4 = word_t'(v2) - r3 - sext(v4);
        expect_store(32'h100, r1);
        expect_store(32'h108, r3);
        expect_store(32'h110, r4);
        run_and_check("arithmetic", 0);
    endtask

    // 36-bit operand from three fields
    task automatic build_wide(input reg_idx_t r, input imm_t f0, input imm_t f1,
                              input imm_t f2);
        add_instr(op_mov_l, r, 0, 0, f0);
        add_instr(op_shftli, r, 0, 0, 12'd12);
        add_instr(op_mov_l, r, 0, 0, f1);
        add_instr(op_shftli, r, 0, 0, 12'd12);
        add_instr(op_mov_l, r, 0, 0, f2);
    endtask

    task automatic test_logic();
        imm_t     f [6];
        imm_t     s;
        imm_t     k1;
        imm_t     k2;
        word_t    x;
        word_t    y;
        word_t    ev [8];
        reg_idx_t src [8];
        clear_test();
        for (int i = 0; i < 6; i++) begin
            f[i] = rand_imm();
        end
        s  = rand_imm() & 12'h03f;
        k1 = (rand_imm() & 12'h01f) + 12'd1;
        k2 = (rand_imm() & 12'h01f) + 12'd1;
        build_wide(1, f[0], f[1], f[2]);
        build_wide(2, f[3], f[4], f[5]);
        add_instr(op_and, 3, 1, 2, 0);
        add_instr(op_or, 4, 1, 2, 0);
        add_instr(op_xor, 5, 1, 2, 0);
        add_instr(op_not, 6, 1, 0, 0);
        add_instr(op_mov_l, 7, 0, 0, s);
        add_instr(op_shftl, 8, 1, 7, 0);
        add_instr(op_shftr, 9, 2, 7, 0);
        add_instr(op_mov, 10, 1, 0, 0);
        add_instr(op_shftri, 10, 0, 0, k1);
        add_instr(op_mov, 11, 2, 0, 0);
        add_instr(op_shftli, 11, 0, 0, k2);
        x = word_t'({f[0], f[1], f[2]});
        y = word_t'({f[3], f[4], f[5]});
        src = '{5'd3, 5'd4, 5'd5, 5'd6, 5'd8, 5'd9, 5'd10, 5'd11};
        ev  = '{x & y, x | y, x ^ y, ~x, x << s, y >> s, x >> k1, y << k2};
        for (int i = 0; i < 8; i++) begin
            add_instr(op_store, 0, src[i], 0, imm_t'(12'h200 + 8 * i));
            expect_store(daddr_t'(32'h200 + 8 * i), ev[i]);
        end
        add_instr(op_halt, 0, 0, 0, 0);
        run_and_check("logic and shifts", 0);
    endtask

    // loads consumed by the very next instruction and negative offsets
    task automatic test_load_use();
        imm_t   v;
        imm_t   v2;
        imm_t   inc;
        imm_t   w;
        word_t  m;
        word_t  e3;
        word_t  e3b;
        daddr_t slot;
        clear_test();
        v   = rand_imm();
        v2  = rand_imm();
        inc = rand_imm();
        w   = rand_imm();
        add_instr(op_mov_l, 1, 0, 0, v);
        add_instr(op_shftli, 1, 0, 0, 12'd20);
        add_instr(op_mov_l, 1, 0, 0, v2);
        add_instr(op_mov_l, 2, 0, 0, 12'h300);
        // offset -8
        add_instr(op_store, 2, 1, 0, 12'hff8);
        add_instr(op_load, 3, 2, 0, 12'hff8);
        add_instr(op_addi, 3, 0, 0, inc);
        add_instr(op_store, 0, 3, 0, 12'h310);
        add_instr(op_mov_l, 3, 0, 0, w);
        add_instr(op_store, 0, 3, 0, 12'h318);
        add_instr(op_load, 4, 2, 0, 12'hff8);
        add_instr(op_add, 5, 4, 3, 0);
        add_instr(op_store, 0, 5, 0, 12'h320);
        add_instr(op_halt, 0, 0, 0, 0);
        m    = (word_t'(v) << 20) | word_t'(v2);
        slot = daddr_t'(word_t'(12'h300) + sext(12'hff8));
        e3   = m + sext(inc);
        // mov_L replaces only bits 11..0
        e3b  = {e3[`XLEN-1:12], w};
        expect_store(slot, m);
        expect_store(32'h310, e3);
        expect_store(32'h318, e3b);
        expect_store(32'h320, m + e3b);
        run_and_check("load-use", 0);
    endtask

    // targets are 0x2000 + 4 * word index
    task automatic test_control();
        imm_t val;
        clear_test();
        val = rand_imm();
        add_instr(op_mov_l, 1, 0, 0, 12'd1);
        add_instr(op_shftli, 1, 0, 0, 12'd13);
        add_instr(op_addi, 1, 0, 0, 12'd32);
        add_instr(op_mov_l, 2, 0, 0, 12'd5);
        add_instr(op_mov_l, 9, 0, 0, val);
        // taken brnz lands on word 8
        add_instr(op_brnz, 1, 2, 0, 0);
        add_instr(op_store, 0, 9, 0, 12'h400);
        add_instr(op_store, 0, 9, 0, 12'h408);
        add_instr(op_store, 0, 9, 0, 12'h410);
        // not taken although the target is the word 6 shadow store
        add_instr(op_mov_l, 3, 0, 0, 12'd1);
        add_instr(op_shftli, 3, 0, 0, 12'd13);
        add_instr(op_addi, 3, 0, 0, 12'd24);
        add_instr(op_brnz, 3, 0, 0, 0);
        add_instr(op_store, 0, 9, 0, 12'h418);
        add_instr(op_store, 0, 9, 0, 12'h420);
        // jump to word 21
        add_instr(op_mov_l, 5, 0, 0, 12'd1);
        add_instr(op_shftli, 5, 0, 0, 12'd13);
        add_instr(op_addi, 5, 0, 0, 12'd84);
        add_instr(op_jump, 5, 0, 0, 0);
        add_instr(op_store, 0, 9, 0, 12'h428);
        add_instr(op_store, 0, 9, 0, 12'h430);
        add_instr(op_store, 0, 9, 0, 12'h438);
        add_instr(op_halt, 0, 0, 0, 0);
        expect_store(32'h410, word_t'(val));
        expect_store(32'h418, word_t'(val));
        expect_store(32'h420, word_t'(val));
        expect_store(32'h438, word_t'(val));
        run_and_check("control flow", 0);
    endtask

    task automatic test_halt();
        imm_t v;
        clear_test();
        v = rand_imm();
        add_instr(op_mov_l, 1, 0, 0, v);
        add_instr(op_store, 0, 1, 0, 12'h500);
        add_instr(op_halt, 0, 0, 0, 0);
        // behind the halt and never written
        add_instr(op_store, 0, 1, 0, 12'h508);
        add_instr(op_store, 0, 1, 0, 12'h510);
        expect_store(32'h500, word_t'(v));
        run_and_check("halt", 20);
    endtask

    initial begin
        seed         = 32'h3eddb87b;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        dmem_updates = 0;
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        dmem_rdata   = '0;
        repeat (2) @(posedge clk);
        test_arith();
        test_logic();
        test_load_use();
        test_control();
        test_halt();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/tinker_pkg.sv
src/instr_mem.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/tinker_core.sv
bench/tinker_core_tb.sv

// File: Bender.yml
package:
  name: tinker_core

sources:
  - include_dirs:
      - src
    files:
      - src/tinker_pkg.sv
      - src/instr_mem.sv
      - src/register_file.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/memory_stage.sv
      - src/tinker_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tinker_core_tb.sv
